/* rtl/dino_params.svh */
`ifndef DINO_PARAMS_SVH
`define DINO_PARAMS_SVH

// playfield geometry
`define FIELD_ROWS   8
`define FIELD_COLS   16   // two 8x8 matrices side by side

`define SPAWN_GAP    4    // ticks between new edge columns
`define SCORE_PERIOD 16   // ticks per point

`define LIVES        3
`define DINO_START   0

// xnor lfsr locks up on all ones
`define LFSR_SEED    32'h0000_0001

`endif

/* rtl/dino_pkg.sv */
`include "dino_params.svh"

package dino_pkg;

    typedef enum logic [1:0] {st_play, st_pause, st_over} game_state_e;

    typedef logic [$clog2(`FIELD_ROWS)-1:0] row_idx_t;
    typedef logic [`FIELD_ROWS-1:0]         col_t;        // bit r is row r
    typedef logic [`FIELD_COLS-1:0]         field_row_t;  // bit 0 is the dino column
    typedef field_row_t [`FIELD_ROWS-1:0]   field_t;
    typedef logic [2:0]                     life_t;
    typedef logic [3:0]                     hex_digit_t;
    typedef logic [6:0]                     seg_t;        // active low

    // obstacle columns, rows 7 down to 0, row 4 always open
    localparam col_t PATTERNS [0:7] = '{
        8'b1110_0000, 8'b0000_1111, 8'b1100_0011, 8'b1110_0000,
        8'b1000_1001, 8'b1000_0111, 8'b1010_0011, 8'b1110_0111
    };

    localparam seg_t SEG_TABLE [0:15] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

endpackage

/* rtl/game_if.sv */
`timescale 1ns/1ps

interface game_if;
    import dino_pkg::*;

    logic     run;        // high in st_play, one tick per cycle
    row_idx_t dino_row;
    logic     hit;
    col_t     spawn_col;  // zero except on spawn ticks

    modport ctrl  (output run, output dino_row, input hit);

    modport gen   (input run, output spawn_col);

    modport field (input run, input dino_row, input spawn_col, output hit);

    // score and scan side
    modport disp  (input run, input dino_row);

endinterface

/* rtl/game_ctrl.sv */
`timescale 1ns/1ps
`include "dino_params.svh"

module game_ctrl (
    input  logic            unit_clk,
    input  logic            restart,
    input  logic            i_stop,
    input  logic            i_up,
    input  logic            i_down,
    game_if.ctrl            gif,
    output dino_pkg::life_t o_life
);
    import dino_pkg::*;

    localparam row_idx_t TOP_ROW = row_idx_t'(`FIELD_ROWS - 1);

    game_state_e state;
    row_idx_t    dino_row;
    life_t       lives;

    always_ff @(posedge unit_clk or negedge restart)
    begin
        if (!restart)
        begin
            state    <= st_play;
            dino_row <= row_idx_t'(`DINO_START);
            lives    <= life_t'(`LIVES);
        end
        else if (state != st_over)  // over holds until restart
        begin
            if (state == st_play)
            begin
                // up has priority over down
                if (i_up)
                begin
                    if (dino_row != TOP_ROW)
                        dino_row <= dino_row + 1'b1;
                end
                else if (i_down)
                begin
                    if (dino_row != '0)
                        dino_row <= dino_row - 1'b1;
                end
            end

            if (gif.hit)
                lives <= lives - 1'b1;

            if (gif.hit && lives == life_t'(1))
                state <= st_over;     // last life gone
            else if (i_stop)
                state <= st_pause;
            else
                state <= st_play;
        end
    end

    assign gif.run      = (state == st_play);
    assign gif.dino_row = dino_row;
    assign o_life       = lives;

endmodule

/* rtl/obstacle_gen.sv */
`timescale 1ns/1ps
`include "dino_params.svh"

module obstacle_gen (
    input  logic unit_clk,
    input  logic restart,
    game_if.gen  gif
);
    import dino_pkg::*;

    localparam int GAP_W = $clog2(`SPAWN_GAP);
    localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`SPAWN_GAP - 1);

    logic [31:0]      lfsr;
    logic             feedback;
    logic [GAP_W-1:0] gap_cnt;

    // taps 32, 22, 2, 1 counted from one
    assign feedback = lfsr[31] ^~ lfsr[21] ^~ lfsr[1] ^~ lfsr[0];

    always_ff @(posedge unit_clk or negedge restart)
    begin
        if (!restart)
        begin
            lfsr    <= `LFSR_SEED;
            gap_cnt <= '0;
        end
        else if (gif.run)
        begin
            lfsr <= {lfsr[30:0], feedback};
            if (gap_cnt == GAP_LAST)
                gap_cnt <= '0;
            else
                gap_cnt <= gap_cnt + 1'b1;
        end
    end

    // new edge column only on the last tick of each gap
    always_comb
    begin
        if (gap_cnt == GAP_LAST)
            gif.spawn_col = PATTERNS[lfsr[2:0]];
        else
            gif.spawn_col = '0;
    end

endmodule

/* rtl/playfield.sv */
`timescale 1ns/1ps
`include "dino_params.svh"

module playfield (
    input  logic             unit_clk,
    input  logic             restart,
    game_if.field            gif,
    output dino_pkg::field_t o_field
);
    import dino_pkg::*;

    field_t field;

    // every tick scrolls toward column 0, spawn column enters at the far edge
    always_ff @(posedge unit_clk or negedge restart)
    begin
        if (!restart)
        begin
            field <= '0;
        end
        else if (gif.run)
        begin
            for (int r = 0; r < `FIELD_ROWS; r++)
            begin
                field[r] <= {gif.spawn_col[r], field[r][`FIELD_COLS-1:1]};
            end
        end
    end

    // collision at the dino cell, lives update on the same edge
    assign gif.hit = gif.run & field[gif.dino_row][0];

    assign o_field = field;

endmodule

/* rtl/score_counter.sv */
`timescale 1ns/1ps
`include "dino_params.svh"

module score_counter (
    input  logic           unit_clk,
    input  logic           restart,
    game_if.disp           gif,
    output dino_pkg::seg_t o_ssd0,
    output dino_pkg::seg_t o_ssd1,
    output dino_pkg::seg_t o_ssd2,
    output dino_pkg::seg_t o_ssd3
);
    import dino_pkg::*;

    localparam int TICK_W = $clog2(`SCORE_PERIOD);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`SCORE_PERIOD - 1);

    logic [TICK_W-1:0] tick_cnt;
    hex_digit_t [3:0]  digits;   // digits[0] is the low digit

    always_ff @(posedge unit_clk or negedge restart)
    begin
        if (!restart)
        begin
            tick_cnt <= '0;
            digits   <= '0;
        end
        else if (gif.run)
        begin
            if (tick_cnt == TICK_LAST)
            begin
                tick_cnt <= '0;
                // carry ripples through all four digits, ffff wraps to 0000
                digits   <= digits + 16'd1;
            end
            else
            begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign o_ssd0 = SEG_TABLE[digits[0]];
    assign o_ssd1 = SEG_TABLE[digits[1]];
    assign o_ssd2 = SEG_TABLE[digits[2]];
    assign o_ssd3 = SEG_TABLE[digits[3]];

endmodule

/* rtl/matrix_scan.sv */
`timescale 1ns/1ps
`include "dino_params.svh"

module matrix_scan (
    input  logic             unit_clk,
    input  logic             restart,
    game_if.disp             gif,
    input  dino_pkg::field_t i_field,
    output logic [7:0]       o_dot_row,
    output logic [7:0]       o_dot_col1,
    output logic [7:0]       o_dot_col2
);
    import dino_pkg::*;

    localparam int HALF = `FIELD_COLS / 2;

    row_idx_t scan_row;

    // free running, state does not matter here
    always_ff @(posedge unit_clk or negedge restart)
    begin
        if (!restart)
        begin
            scan_row   <= '0;
            o_dot_row  <= '1;   // nothing lit
            o_dot_col1 <= '0;
            o_dot_col2 <= '0;
        end
        else
        begin
            o_dot_row  <= ~(8'h80 >> scan_row);   // active low select
            o_dot_col1 <= i_field[scan_row][HALF-1:0]
                          | ((scan_row == gif.dino_row) ? 8'h01 : 8'h00);
            o_dot_col2 <= i_field[scan_row][`FIELD_COLS-1:HALF];
            scan_row   <= scan_row + 1'b1;
        end
    end

endmodule

/* rtl/dino_game_top.sv */
`timescale 1ns/1ps

module dino_game_top (
    input  logic            unit_clk,
    input  logic            restart,
    input  logic            i_stop,
    input  logic            i_up,
    input  logic            i_down,
    output dino_pkg::life_t o_life,
    output dino_pkg::seg_t  o_ssd0,
    output dino_pkg::seg_t  o_ssd1,
    output dino_pkg::seg_t  o_ssd2,
    output dino_pkg::seg_t  o_ssd3,
    output logic [7:0]      o_dot_row,
    output logic [7:0]      o_dot_col1,
    output logic [7:0]      o_dot_col2
);
    import dino_pkg::*;

    field_t field;

    game_if gif ();

    game_ctrl u_ctrl (
        .unit_clk (unit_clk),
        .restart  (restart),
        .i_stop   (i_stop),
        .i_up     (i_up),
        .i_down   (i_down),
        .gif      (gif.ctrl),
        .o_life   (o_life)
    );

    obstacle_gen u_gen (
        .unit_clk (unit_clk),
        .restart  (restart),
        .gif      (gif.gen)
    );

    playfield u_field (
        .unit_clk (unit_clk),
        .restart  (restart),
        .gif      (gif.field),
        .o_field  (field)
    );

    score_counter u_score (
        .unit_clk (unit_clk),
        .restart  (restart),
        .gif      (gif.disp),
        .o_ssd0   (o_ssd0),
        .o_ssd1   (o_ssd1),
        .o_ssd2   (o_ssd2),
        .o_ssd3   (o_ssd3)
    );

    matrix_scan u_scan (
        .unit_clk   (unit_clk),
        .restart    (restart),
        .gif        (gif.disp),
        .i_field    (field),
        .o_dot_row  (o_dot_row),
        .o_dot_col1 (o_dot_col1),
        .o_dot_col2 (o_dot_col2)
    );

endmodule

/* tests/tb_dino_game.sv */
`timescale 1ns/1ps
`include "dino_params.svh"

module tb_dino_game;

    localparam int RESET_CYCLES = 10;
    localparam int GAMES        = 4;
    localparam int GAME_CYCLES  = 400;
    localparam int SAFE_CYCLES  = 700;
    localparam int PAUSE_CYCLES = 200;
    // all phases plus their resets and half again as margin
    localparam int PLANNED      = (GAMES + 1) * (RESET_CYCLES + 2) + GAMES * GAME_CYCLES
                                  + SAFE_CYCLES + PAUSE_CYCLES;
    localparam int CYCLE_LIMIT  = PLANNED + PLANNED / 2;

    localparam logic [1:0] PLAY      = 2'd0;
    localparam logic [1:0] PAUSE     = 2'd1;
    localparam logic [1:0] OVER      = 2'd2;
    localparam logic [1:0] GAP_LAST  = 2'(`SPAWN_GAP - 1);
    localparam logic [3:0] TICK_LAST = 4'(`SCORE_PERIOD - 1);

    logic       unit_clk;
    logic       restart;
    logic       i_stop;
    logic       i_up;
    logic       i_down;
    logic [2:0] o_life;
    logic [6:0] o_ssd0;
    logic [6:0] o_ssd1;
    logic [6:0] o_ssd2;
    logic [6:0] o_ssd3;
    logic [7:0] o_dot_row;
    logic [7:0] o_dot_col1;
    logic [7:0] o_dot_col2;

    // obstacle columns given as rows 7 down to 0
    logic [7:0] pattern_tab [0:7] = '{
        8'b1110_0000, 8'b0000_1111, 8'b1100_0011, 8'b1110_0000,
        8'b1000_1001, 8'b1000_0111, 8'b1010_0011, 8'b1110_0111
    };
    logic [6:0] seg_tab [0:15] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

    // reference model state
    logic [1:0]  m_state;
    logic [2:0]  m_row;
    logic [2:0]  m_lives;
    logic [31:0] m_lfsr;
    logic [1:0]  m_gap;
    logic [15:0] m_field [0:7];
    logic [3:0]  m_tick;
    logic [15:0] m_score;
    logic [2:0]  m_scan;
    logic [7:0]  m_dot_row;
    logic [7:0]  m_col1;
    logic [7:0]  m_col2;

    integer seed = 80;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    string  test_name;

    dino_game_top DUT (
        .unit_clk   (unit_clk),
        .restart    (restart),
        .i_stop     (i_stop),
        .i_up       (i_up),
        .i_down     (i_down),
        .o_life     (o_life),
        .o_ssd0     (o_ssd0),
        .o_ssd1     (o_ssd1),
        .o_ssd2     (o_ssd2),
        .o_ssd3     (o_ssd3),
        .o_dot_row  (o_dot_row),
        .o_dot_col1 (o_dot_col1),
        .o_dot_col2 (o_dot_col2)
    );

    initial
    begin
        unit_clk = 1'b0;
        forever #2 unit_clk = ~unit_clk;
    end

    always @(posedge unit_clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: run went past %0d cycles without reaching the end", CYCLE_LIMIT);
            $display("checks: %0d  errors: %0d  timeouts: 1", checks, errors);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_outputs;
        compare_value({test_name, " o_life"}, 16'(m_lives), 16'(o_life));
        compare_value({test_name, " o_ssd0"}, 16'(seg_tab[m_score[3:0]]), 16'(o_ssd0));
        compare_value({test_name, " o_ssd1"}, 16'(seg_tab[m_score[7:4]]), 16'(o_ssd1));
        compare_value({test_name, " o_ssd2"}, 16'(seg_tab[m_score[11:8]]), 16'(o_ssd2));
        compare_value({test_name, " o_ssd3"}, 16'(seg_tab[m_score[15:12]]), 16'(o_ssd3));
        compare_value({test_name, " o_dot_row"}, 16'(m_dot_row), 16'(o_dot_row));
        compare_value({test_name, " o_dot_col1"}, 16'(m_col1), 16'(o_dot_col1));
        compare_value({test_name, " o_dot_col2"}, 16'(m_col2), 16'(o_dot_col2));
    endtask

    task automatic reset_model;
        m_state   = PLAY;
        m_row     = 3'(`DINO_START);
        m_lives   = 3'(`LIVES);
        m_lfsr    = `LFSR_SEED;
        m_gap     = 2'd0;
        m_tick    = 4'd0;
        m_score   = 16'd0;
        m_scan    = 3'd0;
        m_dot_row = 8'hff;
        m_col1    = 8'h00;
        m_col2    = 8'h00;
        for (int r = 0; r < 8; r++)
            m_field[r] = 16'h0000;
    endtask

    // one clock edge computed from the values before the edge
    task automatic step_model;
        logic       run;
        logic       hit;
        logic       feedback;
        logic [7:0] spawn;
        run   = (m_state == PLAY);
        spawn = (m_gap == GAP_LAST) ? pattern_tab[m_lfsr[2:0]] : 8'h00;
        hit   = run && m_field[m_row][0];

        m_dot_row = 8'hff;
        m_dot_row[3'd7 - m_scan] = 1'b0;
        m_col1    = m_field[m_scan][7:0];
        if (m_scan == m_row)
            m_col1[0] = 1'b1;   // dino cell
        m_col2    = m_field[m_scan][15:8];
        m_scan    = m_scan + 3'd1;

        if (m_state != OVER)
        begin
            if (run)
            begin
                if (i_up)
                begin
                    if (m_row != 3'd7)
                        m_row = m_row + 3'd1;
                end
                else if (i_down && m_row != 3'd0)
                    m_row = m_row - 3'd1;
            end
            if (hit && m_lives == 3'd1)
                m_state = OVER;
            else if (i_stop)
                m_state = PAUSE;
            else
                m_state = PLAY;
            if (hit)
                m_lives = m_lives - 3'd1;
        end

        if (run)
        begin
            feedback = ~(m_lfsr[31] ^ m_lfsr[21] ^ m_lfsr[1] ^ m_lfsr[0]);
            m_lfsr   = {m_lfsr[30:0], feedback};
            m_gap    = (m_gap == GAP_LAST) ? 2'd0 : m_gap + 2'd1;
            for (int r = 0; r < 8; r++)
                m_field[r] = {spawn[r], m_field[r][15:1]};
            if (m_tick == TICK_LAST)
            begin
                m_tick  = 4'd0;
                m_score = m_score + 16'd1;
            end
            else
                m_tick = m_tick + 4'd1;
        end
    endtask

    task automatic drive_cycle(input logic stop, input logic up, input logic down);
        @(posedge unit_clk);
        step_model();
        i_stop <= stop;
        i_up   <= up;
        i_down <= down;
        @(negedge unit_clk);
        check_outputs();
    endtask

    task automatic apply_reset;
        @(posedge unit_clk);
        restart <= 1'b0;
        i_stop  <= 1'b0;
        i_up    <= 1'b0;
        i_down  <= 1'b0;
        repeat (RESET_CYCLES) @(posedge unit_clk);
        restart <= 1'b1;
        reset_model();
        @(negedge unit_clk);
        check_outputs();
    endtask

    initial
    begin
        integer r;
        logic   stop_level;
        int     stretch;
        restart = 1'b0;
        i_stop  = 1'b0;
        i_up    = 1'b0;
        i_down  = 1'b0;

        for (int g = 0; g < GAMES; g++)
        begin
            test_name = $sformatf("random_game%0d", g);
            apply_reset();
            repeat (GAME_CYCLES)
            begin
                r = $random(seed);
                drive_cycle(r[2:0] == 3'd0, r[4], r[5]);  // stop now and then
            end
        end

        // row 4 is open in every pattern
        test_name = "safe";
        apply_reset();
        for (int i = 0; i < SAFE_CYCLES; i++)
            drive_cycle(1'b0, i < 4, 1'b0);
        compare_value("safe lives", 16'(`LIVES), 16'(o_life));
        compare_value("safe score digit1",
                      16'(seg_tab[4'((SAFE_CYCLES / `SCORE_PERIOD) / 16)]), 16'(o_ssd1));

        test_name  = "pause";
        stop_level = 1'b0;
        stretch    = 0;
        repeat (PAUSE_CYCLES)
        begin
            if (stretch == 0)
            begin
                r          = $random(seed);
                stop_level = ~stop_level;
                stretch    = int'(r[3:0]) + 1;
            end
            stretch--;
            r = $random(seed);
            drive_cycle(stop_level, r[0], r[1]);
        end

        $display("checks: %0d  errors: %0d  timeouts: 0", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+rtl
rtl/dino_pkg.sv
rtl/game_if.sv
rtl/game_ctrl.sv
rtl/obstacle_gen.sv
rtl/playfield.sv
rtl/score_counter.sv
rtl/matrix_scan.sv
rtl/dino_game_top.sv
tests/tb_dino_game.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_dino_game -o sim_dino

out=$(./obj_dir/sim_dino)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
else
    exit 1
fi
